//--- sim.f
switch_cfg_pkg.sv
switch_types_pkg.sv
fifo_sync.sv
ingress_queues.sv
route_arbiter.sv
egress_queues.sv
flow_ctrl_fsm.sv
switch_top.sv
tb_switch.sv

//--- tb_switch.sv
`timescale 1ns/100ps

module tb_switch;

	import switch_cfg_pkg::*;
	import switch_types_pkg::*;

	localparam int FIFO_DEPTH     = 8;
	localparam int TOTAL_WORDS    = 16 + 8 + 12 + 200;  // Routing, priority, back-pressure, random
	localparam int TIMEOUT_CYCLES = TOTAL_WORDS * 20 + 500;
	localparam int MODEL_SLOTS    = TOTAL_WORDS + 1;    // Model queues never wrap

	// Expected outcome of one arbitration
	typedef struct packed {
		logic       valid;
		logic [1:0] src;   // Ingress port popped
		dest_t      dest;  // Egress port pushed
		word_t      word;
	} ref_xfer_t;

	logic               clk;
	logic               arst_n;
	logic               init;
	thr_t               thr_in;
	port_vec_t          in_push;
	word_t [NPORTS-1:0] in_word;
	port_vec_t          in_full;
	port_vec_t          out_pop;
	word_t [NPORTS-1:0] out_word;
	port_vec_t          out_empty;
	port_vec_t          eg_afull;
	ctrl_state_t        state;

	// Reference model of queues and controller
	word_t       m_in_q [NPORTS][MODEL_SLOTS];
	word_t       m_eg_q [NPORTS][MODEL_SLOTS];
	int          m_in_rd [NPORTS];
	int          m_in_wr [NPORTS];
	int          m_eg_rd [NPORTS];
	int          m_eg_wr [NPORTS];
	ctrl_state_t m_state = ST_RESET;
	thr_t        m_thr = thr_t'(AF_THR_DEFAULT);
	int          m_accepted = 0;   // Words taken by ingress
	int          m_delivered = 0;  // Words popped at egress
	int          n_issued = 0;     // Words driven by stimulus
	integer      seed = 47;

	switch_top #(
		.FIFO_DEPTH(FIFO_DEPTH)
	) dut (
		.clk       (clk),
		.arst_n    (arst_n),
		.init      (init),
		.thr_in    (thr_in),
		.in_push   (in_push),
		.in_word   (in_word),
		.in_full   (in_full),
		.out_pop   (out_pop),
		.out_word  (out_word),
		.out_empty (out_empty),
		.eg_afull  (eg_afull),
		.state     (state)
	);

	initial clk = 1'b0;
	always #5 clk = ~clk;  // 10 ns period

	task automatic stop_with_error(input string msg);
		$display("%s", msg);
		$display("Simulation FAILED");
		$fatal(1);
	endtask

	task automatic check_value(input string name, input logic [31:0] got, input logic [31:0] exp);
		if (got !== exp) begin
			stop_with_error($sformatf("FAIL %s expected 0x%0h got 0x%0h", name, exp, got));
		end
	endtask

	// Lowest non-empty ingress wins, word routed by its top bits
	function automatic ref_xfer_t ref_transfer(input word_t [NPORTS-1:0] heads,
			input port_vec_t nonempty, input logic allowed);
		ref_xfer_t r;
		r = '0;
		if (allowed) begin
			for (int p = NPORTS - 1; p >= 0; p--) begin  // Scanned downward so port 0 lands last
				if (nonempty[p]) begin
					r.valid = 1'b1;
					r.src   = 2'(p);
				end
			end
			if (r.valid) begin
				r.word = heads[r.src];
				r.dest = r.word[WORD_W-1 -: DEST_W];
			end
		end
		return r;
	endfunction

	function automatic logic model_any_afull();
		for (int i = 0; i < NPORTS; i++) begin
			if (m_eg_wr[i] - m_eg_rd[i] >= m_thr) return 1'b1;
		end
		return 1'b0;
	endfunction

	function automatic logic model_in_empty();
		for (int i = 0; i < NPORTS; i++) begin
			if (m_in_wr[i] != m_in_rd[i]) return 1'b0;
		end
		return 1'b1;
	endfunction

	// Model advances on the same edge as the DUT, from pre-edge values
	always @(posedge clk) begin : model_update
		ref_xfer_t          t;
		word_t [NPORTS-1:0] heads;
		port_vec_t          in_ne;
		port_vec_t          eg_ne;
		int                 in_lvl [NPORTS];
		int                 eg_lvl [NPORTS];
		ctrl_state_t        nxt;
		if (!arst_n) begin
			for (int i = 0; i < NPORTS; i++) begin
				m_in_rd[i] = 0;
				m_in_wr[i] = 0;
				m_eg_rd[i] = 0;
				m_eg_wr[i] = 0;
			end
			m_state = ST_RESET;
			m_thr   = thr_t'(AF_THR_DEFAULT);
		end else begin
			for (int i = 0; i < NPORTS; i++) begin
				in_lvl[i] = m_in_wr[i] - m_in_rd[i];
				eg_lvl[i] = m_eg_wr[i] - m_eg_rd[i];
				in_ne[i]  = (in_lvl[i] != 0);
				eg_ne[i]  = (eg_lvl[i] != 0);
				heads[i]  = m_in_q[i][m_in_rd[i]];
			end
			t = ref_transfer(heads, in_ne,
				(m_state == ST_IDLE || m_state == ST_ACTIVE) && !model_any_afull());
			for (int i = 0; i < NPORTS; i++) begin
				if (out_pop[i] && eg_ne[i]) begin  // Pop of empty is ignored
					m_eg_rd[i]++;
					m_delivered++;
				end
				if (in_push[i] && in_lvl[i] < FIFO_DEPTH) begin  // Full drops the push
					m_in_q[i][m_in_wr[i]] = in_word[i];
					m_in_wr[i]++;
					m_accepted++;
				end
			end
			if (t.valid) begin
				m_in_rd[t.src]++;
				if (eg_lvl[t.dest] < FIFO_DEPTH) begin
					m_eg_q[t.dest][m_eg_wr[t.dest]] = t.word;
					m_eg_wr[t.dest]++;
				end
			end
			if (m_state == ST_INIT && init) m_thr = thr_in;  // Captured every init edge
			nxt = m_state;
			case (m_state)
				ST_RESET:  nxt = ST_INIT;
				ST_INIT:   if (!init) nxt = ST_IDLE;
				ST_IDLE:   if (in_ne != '0) nxt = ST_ACTIVE;
				ST_ACTIVE: if (in_ne == '0 && eg_ne == '0) nxt = ST_IDLE;
				default:   nxt = ST_RESET;
			endcase
			m_state = init ? ST_INIT : nxt;
		end
	end

	// Outputs are compared mid-cycle where they are settled
	always @(negedge clk) begin : compare
		port_vec_t exp_empty;
		port_vec_t exp_afull;
		port_vec_t exp_full;
		for (int i = 0; i < NPORTS; i++) begin
			exp_empty[i] = (m_eg_wr[i] == m_eg_rd[i]);
			exp_afull[i] = (m_eg_wr[i] - m_eg_rd[i] >= m_thr);
			exp_full[i]  = (m_in_wr[i] - m_in_rd[i] == FIFO_DEPTH);
		end
		check_value("state", 32'(state), 32'(m_state));
		check_value("out_empty", 32'(out_empty), 32'(exp_empty));
		check_value("eg_afull", 32'(eg_afull), 32'(exp_afull));
		check_value("in_full", 32'(in_full), 32'(exp_full));
		for (int i = 0; i < NPORTS; i++) begin
			if (!exp_empty[i]) begin  // Head must match model order
				check_value($sformatf("out_word[%0d]", i), 32'(out_word[i]),
					32'(m_eg_q[i][m_eg_rd[i]]));
			end
		end
	end

	task automatic wait_state(input ctrl_state_t target, input int limit);
		int n;
		n = 0;
		@(negedge clk);
		while (state !== target) begin
			if (n >= limit) stop_with_error($sformatf("State never reached %s", target.name()));
			n++;
			@(negedge clk);
		end
	endtask

	task automatic push_one(input int port, input word_t w);
		@(posedge clk);
		while (in_full[port]) @(posedge clk);  // Hold while queue is full
		in_push     <= port_vec_t'(1 << port);
		in_word[port] <= w;
		n_issued++;
		@(posedge clk);
		in_push <= '0;
	endtask

	task automatic wait_drain();
		while (m_delivered != n_issued) @(negedge clk);  // Watchdog covers a lost word
	endtask

	task automatic start_init(input thr_t thr);
		@(posedge clk);
		init   <= 1'b1;
		thr_in <= thr;
		repeat (2) @(posedge clk);
	endtask

	task automatic end_init();
		@(posedge clk);
		init <= 1'b0;
		wait_state(ST_IDLE, 4);
	endtask

	initial begin : watchdog
		repeat (TIMEOUT_CYCLES) @(posedge clk);
		stop_with_error($sformatf("Timeout after %0d cycles, traffic did not drain",
			TIMEOUT_CYCLES));
	end

	initial begin : stimulus
		word_t     w;
		port_vec_t push_v;
		port_vec_t last_v;
		int        k;
		arst_n  = 1'b0;
		init    = 1'b0;
		thr_in  = '0;
		in_push = '0;
		in_word = '0;
		out_pop = '0;
		repeat (4) @(posedge clk);  // Four edges in reset
		arst_n <= 1'b1;
		wait_state(ST_INIT, 4);
		start_init(8'd3);
		end_init();

		// Routing, every destination from every port
		@(posedge clk);
		out_pop <= '1;
		for (int p = 0; p < NPORTS; p++) begin
			for (int d = 0; d < NPORTS; d++) begin
				w = word_t'($random(seed));
				w[WORD_W-1 -: DEST_W] = dest_t'(d);
				push_one(p, w);
				wait_state(ST_ACTIVE, 4);
				wait_drain();
				wait_state(ST_IDLE, 4);
			end
		end

		// Priority, all ports preloaded while disabled
		@(posedge clk);
		out_pop <= '0;
		start_init(8'd6);
		for (int r = 0; r < 2; r++) begin
			@(posedge clk);
			in_push <= '1;
			for (int p = 0; p < NPORTS; p++) in_word[p] <= word_t'($random(seed));
			n_issued += NPORTS;
			@(posedge clk);
			in_push <= '0;
		end
		end_init();
		while (!(model_in_empty() || model_any_afull())) @(negedge clk);
		repeat (4) @(posedge clk);
		out_pop <= '1;  // Drain late
		wait_drain();
		wait_state(ST_IDLE, 4);

		// Back-pressure at threshold 3, port 1 fills first
		start_init(8'd3);
		end_init();
		@(posedge clk);
		out_pop <= '0;
		for (int r = 0; r < 3; r++) begin
			@(posedge clk);
			in_push <= '1;
			for (int p = 0; p < NPORTS; p++) begin
				w = word_t'($random(seed));
				w[WORD_W-1 -: DEST_W] = (r == 0) ? dest_t'(1) : dest_t'(p);
				in_word[p] <= w;
			end
			n_issued += NPORTS;
			@(posedge clk);
			in_push <= '0;
		end
		while (!model_any_afull()) @(negedge clk);
		repeat (8) @(negedge clk);  // Stalled, compare holds every cycle
		// Two port 1 words from round 0 and one from round 1, a single port 0 word between
		check_value("eg_afull", 32'(eg_afull), 32'h2);
		check_value("out_empty", 32'(out_empty), 32'hc);  // Ports 2 and 3 got nothing
		@(posedge clk);
		out_pop <= '1;
		wait_drain();
		wait_state(ST_IDLE, 4);

		// Random traffic with random egress pops
		k      = 0;
		last_v = '0;
		while (k < 200) begin
			@(posedge clk);
			push_v = '0;
			for (int p = 0; p < NPORTS; p++) begin
				if (!last_v[p] && !in_full[p] && k < 200 && ($random(seed) & 1) != 0) begin
					push_v[p] = 1'b1;
					in_word[p] <= word_t'($random(seed));
					k++;
					n_issued++;
				end
			end
			in_push <= push_v;
			last_v  = push_v;  // No back-to-back push on one port
			out_pop <= port_vec_t'($random(seed));
		end
		@(posedge clk);
		in_push <= '0;
		out_pop <= '1;
		wait_drain();
		wait_state(ST_IDLE, 4);

		repeat (4) @(posedge clk);
		if (n_issued == m_accepted && m_delivered == m_accepted) begin
			$display("Simulation PASSED");
			$finish;
		end else begin
			stop_with_error($sformatf("Word count mismatch, issued %0d accepted %0d delivered %0d",
				n_issued, m_accepted, m_delivered));
		end
	end

endmodule

//--- switch_top.sv
`timescale 1ns/100ps

module switch_top #(
	parameter int FIFO_DEPTH = switch_cfg_pkg::DEPTH_DEFAULT  // Depth of all eight queues
) (
	input  logic                                                 clk,
	input  logic                                                 arst_n,
	// Control
	input  logic                                                 init,
	input  switch_types_pkg::thr_t                               thr_in,
	// Ingress
	input  switch_types_pkg::port_vec_t                          in_push,
	input  switch_types_pkg::word_t [switch_cfg_pkg::NPORTS-1:0] in_word,
	output switch_types_pkg::port_vec_t                          in_full,
	// Egress
	input  switch_types_pkg::port_vec_t                          out_pop,
	output switch_types_pkg::word_t [switch_cfg_pkg::NPORTS-1:0] out_word,
	output switch_types_pkg::port_vec_t                          out_empty,
	output switch_types_pkg::port_vec_t                          eg_afull,
	// Status
	output switch_types_pkg::ctrl_state_t                        state
);

	import switch_types_pkg::*;

	ingress_stat_t in_stat;  // Ingress heads and empties
	port_vec_t     in_pop;   // Arbiter pops
	xfer_t         xfer;     // Arbiter pushes and word
	logic          arb_en;
	thr_t          af_thr;   // Shared almost-full level

	ingress_queues #(
		.FIFO_DEPTH(FIFO_DEPTH)
	) u_ingress (
		.clk     (clk),
		.arst_n  (arst_n),
		.in_push (in_push),
		.in_word (in_word),
		.pop     (in_pop),
		.af_thr  (af_thr),
		.stat    (in_stat),
		.in_full (in_full)
	);

	route_arbiter u_arbiter (
		.arb_en   (arb_en),
		.stat     (in_stat),
		.eg_afull (eg_afull),
		.pop      (in_pop),
		.xfer     (xfer)
	);

	egress_queues #(
		.FIFO_DEPTH(FIFO_DEPTH)
	) u_egress (
		.clk       (clk),
		.arst_n    (arst_n),
		.xfer      (xfer),
		.out_pop   (out_pop),
		.af_thr    (af_thr),
		.out_word  (out_word),
		.out_empty (out_empty),
		.eg_afull  (eg_afull)
	);

	flow_ctrl_fsm u_ctrl (
		.clk       (clk),
		.arst_n    (arst_n),
		.init      (init),
		.thr_in    (thr_in),
		.in_empty  (in_stat.empty),
		.out_empty (out_empty),
		.arb_en    (arb_en),
		.af_thr    (af_thr),
		.state     (state)
	);

endmodule

//--- flow_ctrl_fsm.sv
`timescale 1ns/100ps

module flow_ctrl_fsm (
	input  logic                          clk,
	input  logic                          arst_n,
	input  logic                          init,       // Level, forces ST_INIT
	input  switch_types_pkg::thr_t        thr_in,     // Captured during init
	input  switch_types_pkg::port_vec_t   in_empty,   // Ingress empties
	input  switch_types_pkg::port_vec_t   out_empty,  // Egress empties
	output logic                          arb_en,
	output switch_types_pkg::thr_t        af_thr,     // To both queue blocks
	output switch_types_pkg::ctrl_state_t state
);

	import switch_cfg_pkg::*;
	import switch_types_pkg::*;

	ctrl_state_t state_nxt;
	logic        in_all_empty;   // No ingress word waiting
	logic        out_all_empty;  // No egress word waiting

	assign in_all_empty  = &in_empty;
	assign out_all_empty = &out_empty;

	// Next state
	always_comb begin
		state_nxt = state;
		case (state)
			ST_RESET:  state_nxt = ST_INIT;  // First edge after release
			ST_INIT: begin
				if (!init) state_nxt = ST_IDLE;
			end
			ST_IDLE: begin
				if (!in_all_empty) state_nxt = ST_ACTIVE;  // Traffic arrived
			end
			ST_ACTIVE: begin
				if (in_all_empty && out_all_empty) begin
					state_nxt = ST_IDLE;  // Fully drained
				end
			end
			default:   state_nxt = ST_RESET;
		endcase
		// Init wins from any state
		if (init) begin
			state_nxt = ST_INIT;
		end
	end

	// State register
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			state <= ST_RESET;
		end else begin
			state <= state_nxt;
		end
	end

	// Threshold register
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			af_thr <= thr_t'(AF_THR_DEFAULT);
		end else if (state == ST_INIT && init) begin
			af_thr <= thr_in;  // Every edge while init holds
		end
	end

	// Arbiter runs only once configured
	assign arb_en = (state == ST_IDLE) || (state == ST_ACTIVE);

endmodule

//--- egress_queues.sv
`timescale 1ns/100ps

module egress_queues #(
	parameter int FIFO_DEPTH = switch_cfg_pkg::DEPTH_DEFAULT
) (
	input  logic                                                 clk,
	input  logic                                                 arst_n,
	// From the arbiter
	input  switch_types_pkg::xfer_t                              xfer,
	// From outside
	input  switch_types_pkg::port_vec_t                          out_pop,
	// From the controller
	input  switch_types_pkg::thr_t                               af_thr,
	// Toward outside
	output switch_types_pkg::word_t [switch_cfg_pkg::NPORTS-1:0] out_word,  // Heads
	output switch_types_pkg::port_vec_t                          out_empty,
	output switch_types_pkg::port_vec_t                          eg_afull   // Back-pressure
);

	import switch_cfg_pkg::*;
	import switch_types_pkg::*;

	port_vec_t push;   // Per-queue write strobe
	word_t     wdata;  // Shared write word

	// Unpack the transfer
	assign push  = xfer.push;
	assign wdata = xfer.word;

	// One queue per egress port
	for (genvar i = 0; i < NPORTS; i++) begin : g_out_q
		fifo_sync #(
			.FIFO_DEPTH(FIFO_DEPTH)
		) u_fifo (
			.clk         (clk),
			.arst_n      (arst_n),
			.push        (push[i]),
			.pop         (out_pop[i]),  // Ignored while empty
			.wdata       (wdata),
			.af_thr      (af_thr),
			.rdata       (out_word[i]),
			.empty       (out_empty[i]),
			.full        (),            // Arbiter stops on almost-full first
			.almost_full (eg_afull[i])
		);
	end

endmodule

//--- route_arbiter.sv
`timescale 1ns/100ps

module route_arbiter (
	input  logic                            arb_en,    // From the controller
	input  switch_types_pkg::ingress_stat_t stat,      // Heads and empties
	input  switch_types_pkg::port_vec_t     eg_afull,  // Egress back-pressure
	output switch_types_pkg::port_vec_t     pop,       // Toward ingress queues
	output switch_types_pkg::xfer_t         xfer       // Toward egress queues
);

	import switch_cfg_pkg::*;
	import switch_types_pkg::*;

	logic  go;        // Transfer allowed this cycle
	word_t mux_word;  // Selected head
	dest_t dest;      // Its egress port

	// Any almost-full egress stops everything
	assign go = arb_en && !(|eg_afull);

	// Fixed priority pop with port 0 first
	always_comb begin
		pop = '0;
		if (go) begin
			if (!stat.empty[0]) begin
				pop[0] = 1'b1;
			end else if (!stat.empty[1]) begin
				pop[1] = 1'b1;
			end else if (!stat.empty[2]) begin
				pop[2] = 1'b1;
			end else if (!stat.empty[3]) begin
				pop[3] = 1'b1;
			end
		end
	end

	// Word mux follows the pop
	always_comb begin
		mux_word = '0;  // Nothing popped
		if (pop[0]) begin
			mux_word = stat.head[0];
		end else if (pop[1]) begin
			mux_word = stat.head[1];
		end else if (pop[2]) begin
			mux_word = stat.head[2];
		end else if (pop[3]) begin
			mux_word = stat.head[3];
		end
	end

	// Destination in the top bits
	assign dest = mux_word[WORD_W-1 -: DEST_W];

	// Push decode
	always_comb begin
		xfer = '0;
		if (|pop) begin
			xfer.word = mux_word;  // Forwarded unchanged
			case (dest)
				2'd0:    xfer.push[0] = 1'b1;
				2'd1:    xfer.push[1] = 1'b1;
				2'd2:    xfer.push[2] = 1'b1;
				default: xfer.push[3] = 1'b1;
			endcase
		end
	end

endmodule

//--- ingress_queues.sv
`timescale 1ns/100ps

module ingress_queues #(
	parameter int FIFO_DEPTH = switch_cfg_pkg::DEPTH_DEFAULT
) (
	input  logic                                                 clk,
	input  logic                                                 arst_n,
	// From outside
	input  switch_types_pkg::port_vec_t                          in_push,
	input  switch_types_pkg::word_t [switch_cfg_pkg::NPORTS-1:0] in_word,
	// From the arbiter
	input  switch_types_pkg::port_vec_t                          pop,
	// From the controller
	input  switch_types_pkg::thr_t                               af_thr,
	// Heads and empties toward the arbiter
	output switch_types_pkg::ingress_stat_t                      stat,
	output switch_types_pkg::port_vec_t                          in_full   // Driver must hold
);

	import switch_cfg_pkg::*;
	import switch_types_pkg::*;

	word_t [NPORTS-1:0] head;   // Per-queue head word
	port_vec_t          empty;  // Per-queue empty flag

	// One queue per ingress port
	for (genvar i = 0; i < NPORTS; i++) begin : g_in_q
		fifo_sync #(
			.FIFO_DEPTH(FIFO_DEPTH)
		) u_fifo (
			.clk         (clk),
			.arst_n      (arst_n),
			.push        (in_push[i]),
			.pop         (pop[i]),      // Same edge as the transfer
			.wdata       (in_word[i]),
			.af_thr      (af_thr),
			.rdata       (head[i]),
			.empty       (empty[i]),
			.full        (in_full[i]),
			.almost_full ()             // Ingress level not needed
		);
	end

	// Pack status for the arbiter
	assign stat.head  = head;
	assign stat.empty = empty;

endmodule

//--- fifo_sync.sv
`timescale 1ns/100ps

module fifo_sync #(
	parameter int FIFO_DEPTH = switch_cfg_pkg::DEPTH_DEFAULT  // Words held
) (
	input  logic                    clk,
	input  logic                    arst_n,
	input  logic                    push,         // Write strobe
	input  logic                    pop,          // Advance head on the edge
	input  switch_types_pkg::word_t wdata,
	input  switch_types_pkg::thr_t  af_thr,       // Almost-full level
	output switch_types_pkg::word_t rdata,        // Head word
	output logic                    empty,
	output logic                    full,
	output logic                    almost_full
);

	import switch_types_pkg::*;

	localparam int PTR_W = (FIFO_DEPTH > 1) ? $clog2(FIFO_DEPTH) : 1;
	localparam int CNT_W = $clog2(FIFO_DEPTH + 1);  // Holds 0 up to FIFO_DEPTH

	word_t            mem [FIFO_DEPTH];  // Circular buffer
	logic [PTR_W-1:0] wr_ptr;
	logic [PTR_W-1:0] rd_ptr;
	logic [CNT_W-1:0] count;             // Occupancy
	logic             do_push;
	logic             do_pop;

	// Next slot with wrap for any depth
	function automatic logic [PTR_W-1:0] ptr_inc(input logic [PTR_W-1:0] p);
		if (p == PTR_W'(FIFO_DEPTH - 1)) begin
			return '0;
		end
		return p + 1'b1;
	endfunction

	assign do_push = push && !full;   // Push to a full queue is dropped
	assign do_pop  = pop && !empty;   // Pop of an empty queue is ignored

	// Storage
	always_ff @(posedge clk) begin
		if (do_push) begin
			mem[wr_ptr] <= wdata;
		end
	end

	// Pointers and count
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
		end else begin
			if (do_push) wr_ptr <= ptr_inc(wr_ptr);
			if (do_pop) rd_ptr <= ptr_inc(rd_ptr);
			case ({do_push, do_pop})
				2'b10:   count <= count + 1'b1;
				2'b01:   count <= count - 1'b1;
				default: count <= count;  // Both or neither keep the level
			endcase
		end
	end

	// Head falls through
	assign rdata = mem[rd_ptr];

	// Status flags
	assign empty       = (count == '0);
	assign full        = (count == CNT_W'(FIFO_DEPTH));
	assign almost_full = (thr_t'(count) >= af_thr);  // Count at or above the level

endmodule

//--- switch_types_pkg.sv
package switch_types_pkg;

	import switch_cfg_pkg::*;

	// Plain vectors
	typedef logic [WORD_W-1:0] word_t;      // One data word
	typedef logic [DEST_W-1:0] dest_t;      // Egress port index
	typedef logic [NPORTS-1:0] port_vec_t;  // One flag per port
	typedef logic [7:0]        thr_t;       // Almost-full level against occupancy

	// Controller states
	typedef enum logic [1:0] {
		ST_RESET,   // Held while arst_n is low
		ST_INIT,    // Threshold capture
		ST_IDLE,    // Enabled with nothing queued
		ST_ACTIVE   // Traffic in flight
	} ctrl_state_t;

	// Ingress side to arbiter
	typedef struct packed {
		word_t [NPORTS-1:0] head;   // First-word-fall-through heads
		port_vec_t          empty;  // Head valid when its bit is 0
	} ingress_stat_t;

	// Arbiter to egress side
	typedef struct packed {
		port_vec_t push;  // At most one bit set
		word_t     word;  // Shared write word
	} xfer_t;

endpackage

//--- switch_cfg_pkg.sv
package switch_cfg_pkg;

	// Word layout
	parameter int WORD_W = 10;  // Bits in one switched word
	parameter int DEST_W = 2;   // Destination field width

	// The destination sits in the top DEST_W bits of each word
	// Bits below it are payload and pass through untouched

	// Port count
	parameter int NPORTS = 4;   // Ingress and egress alike

	// Queue sizing
	parameter int DEPTH_DEFAULT = 8;   // Words per queue unless the top overrides it

	// Flow control
	parameter int AF_THR_DEFAULT = 6;  // Almost-full level used before init

	// Sanity of the layout
	// DEST_W must address all NPORTS egress queues
	// WORD_W must leave room for the destination field

endpackage
